//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_riscv_core
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- alu.sv
module alu (
	input core_pkg::word_t a,
	input core_pkg::word_t b,
	input core_pkg::alu_op_t op,
	output core_pkg::word_t result,
	output core_pkg::alu_flags_t flags
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb
	begin
		case (op)
			core_pkg::alu_add: result = a + b;
			core_pkg::alu_sub: result = a - b;
			core_pkg::alu_and: result = a & b;
			core_pkg::alu_or: result = a | b;
			core_pkg::alu_xor: result = a ^ b;
			core_pkg::alu_sll: result = a << shamt;
			core_pkg::alu_srl: result = a >> shamt;
			core_pkg::alu_sra: result = $signed(a) >>> shamt;	// sign fill
			default: result = a + b;
		endcase
	end

	// compare flags ignore op
	assign flags.eq = a == b;
	assign flags.lt = $signed(a) < $signed(b);
	assign flags.ltu = a < b;

endmodule

//--- control_fsm.sv
module control_fsm #(
	parameter int fetch_cycles = 2,
	parameter int alu_cycles = 2
) (
	input logic clk,
	input logic rst,
	input core_pkg::word_t instr,
	input core_pkg::word_t rs1_data,
	input core_pkg::alu_flags_t flags,
	input logic [7:0] count,
	output core_pkg::ctrl_t ctrl,
	output logic timer_clear,
	output logic timer_run,
	output logic print_valid,
	output logic halted
);

	core_pkg::state_t state;
	core_pkg::state_t next_state;
	core_pkg::alu_op_t alu_op;
	core_pkg::word_t imm_i;
	core_pkg::word_t imm_u;
	core_pkg::word_t imm_b;
	core_pkg::word_t imm_j;
	logic [2:0] funct3;
	logic fetch_done;
	logic alu_done;
	logic waiting;
	logic cmp;
	logic taken;

	assign funct3 = instr[14:12];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'd0};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	assign fetch_done = count >= 8'(fetch_cycles);
	assign alu_done = count >= 8'(alu_cycles);

	// beq/bne, blt/bge, bltu/bgeu; funct3[0] inverts
	assign cmp = funct3[2] ? (funct3[1] ? flags.ltu : flags.lt) : flags.eq;
	assign taken = cmp ^ funct3[0];

	assign waiting = state inside {core_pkg::st_fetch, core_pkg::st_regi,
		core_pkg::st_regreg, core_pkg::st_branch_cmp, core_pkg::st_ecall};
	assign timer_run = waiting;
	assign timer_clear = !waiting;

	assign print_valid = state == core_pkg::st_print;
	assign halted = state == core_pkg::st_halt;

	// ------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= core_pkg::st_fetch;
		end
		else
		begin
			state <= next_state;
		end
	end

	always_comb
	begin
		next_state = core_pkg::st_halt;
		case (state)
			core_pkg::st_fetch:
				next_state = fetch_done ? core_pkg::st_decode : core_pkg::st_fetch;
			core_pkg::st_decode:
			begin
				case (instr[6:0])
					core_pkg::opc_lui:
						next_state = core_pkg::st_lui;
					core_pkg::opc_op_imm:	// slti/sltiu not supported
						next_state = (funct3[2:1] == 2'b01) ? core_pkg::st_halt : core_pkg::st_regi;
					core_pkg::opc_op:
						next_state = (funct3[2:1] == 2'b01) ? core_pkg::st_halt : core_pkg::st_regreg;
					core_pkg::opc_branch:
						next_state = (funct3[2:1] == 2'b01) ? core_pkg::st_halt : core_pkg::st_branch_cmp;
					core_pkg::opc_jal:
						next_state = core_pkg::st_jal_link;
					core_pkg::opc_system:	// plain ecall only
						next_state = (instr[31:7] == '0) ? core_pkg::st_ecall : core_pkg::st_halt;
					default:
						next_state = core_pkg::st_halt;
				endcase
			end
			core_pkg::st_lui:
				next_state = core_pkg::st_advance_pc;
			core_pkg::st_regi:
				next_state = alu_done ? core_pkg::st_advance_pc : core_pkg::st_regi;
			core_pkg::st_regreg:
				next_state = alu_done ? core_pkg::st_advance_pc : core_pkg::st_regreg;
			core_pkg::st_branch_cmp:
			begin
				if (!alu_done)
					next_state = core_pkg::st_branch_cmp;
				else
					next_state = taken ? core_pkg::st_branch_take : core_pkg::st_advance_pc;
			end
			core_pkg::st_branch_take:
				next_state = core_pkg::st_settle;
			core_pkg::st_jal_link:
				next_state = core_pkg::st_jal_jump;
			core_pkg::st_jal_jump:
				next_state = core_pkg::st_settle;
			core_pkg::st_ecall:
			begin
				if (!alu_done)
					next_state = core_pkg::st_ecall;
				else
					next_state = (rs1_data == 32'd1) ? core_pkg::st_print : core_pkg::st_halt;
			end
			core_pkg::st_print:
				next_state = core_pkg::st_advance_pc;
			core_pkg::st_advance_pc:
				next_state = core_pkg::st_settle;
			core_pkg::st_settle:
				next_state = core_pkg::st_fetch;
			default:
				next_state = core_pkg::st_halt;
		endcase
	end

	// ------------------------------
	always_comb
	begin
		case (funct3)
			3'b000: alu_op = (instr[5] && instr[30]) ? core_pkg::alu_sub : core_pkg::alu_add;
			3'b001: alu_op = core_pkg::alu_sll;
			3'b100: alu_op = core_pkg::alu_xor;
			3'b101: alu_op = instr[30] ? core_pkg::alu_sra : core_pkg::alu_srl;
			3'b110: alu_op = core_pkg::alu_or;
			3'b111: alu_op = core_pkg::alu_and;
			default: alu_op = core_pkg::alu_add;
		endcase
	end

	always_comb
	begin
		ctrl = '0;
		ctrl.rd = instr[11:7];
		ctrl.rs1 = instr[19:15];
		ctrl.rs2 = instr[24:20];
		ctrl.wb_sel = core_pkg::wb_alu;
		ctrl.alu_op = alu_op;
		ctrl.imm = imm_i;
		case (state)
			core_pkg::st_fetch:
				ctrl.ir_we = fetch_done;	// last fetch cycle
			core_pkg::st_lui:
			begin
				ctrl.imm = imm_u;
				ctrl.wb_sel = core_pkg::wb_imm;
				ctrl.reg_we = 1'b1;
			end
			core_pkg::st_regi:
			begin
				ctrl.alu_b_imm = 1'b1;
				ctrl.reg_we = alu_done;
			end
			core_pkg::st_regreg:
				ctrl.reg_we = alu_done;
			core_pkg::st_branch_cmp:
				ctrl.imm = imm_b;
			core_pkg::st_branch_take:
			begin
				ctrl.imm = imm_b;
				ctrl.pc_we = 1'b1;
				ctrl.pc_branch = 1'b1;
			end
			core_pkg::st_jal_link:
			begin
				ctrl.imm = imm_j;
				ctrl.wb_sel = core_pkg::wb_pc4;
				ctrl.reg_we = 1'b1;
			end
			core_pkg::st_jal_jump:
			begin
				ctrl.imm = imm_j;
				ctrl.pc_we = 1'b1;
				ctrl.pc_branch = 1'b1;
			end
			core_pkg::st_ecall:
				ctrl.rs1 = core_pkg::reg_a0;
			core_pkg::st_print:
				ctrl.rs2 = core_pkg::reg_a1;	// goes out as print_data
			core_pkg::st_advance_pc:
				ctrl.pc_we = 1'b1;
			default:
			begin
			end
		endcase
	end

endmodule

//--- core_pkg.sv
package core_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam reg_addr_t reg_a0 = 5'd10;	// ecall function code
	localparam reg_addr_t reg_a1 = 5'd11;	// ecall argument

	// ------------------------------
	typedef enum logic [6:0] {
		opc_lui = 7'b0110111,
		opc_op_imm = 7'b0010011,
		opc_op = 7'b0110011,
		opc_branch = 7'b1100011,
		opc_jal = 7'b1101111,
		opc_system = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_imm,
		wb_pc4
	} wb_sel_t;

	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_lui,
		st_regi,
		st_regreg,
		st_branch_cmp,
		st_branch_take,
		st_jal_link,
		st_jal_jump,
		st_ecall,
		st_print,
		st_advance_pc,
		st_settle,
		st_halt
	} state_t;

	// ------------------------------
	typedef struct packed {
		logic reg_we;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		wb_sel_t wb_sel;
		alu_op_t alu_op;
		logic alu_b_imm;	// b operand from imm
		word_t imm;
		logic pc_we;
		logic pc_branch;	// pc + imm instead of pc + 4
		logic ir_we;
	} ctrl_t;

	typedef struct packed {
		logic eq;
		logic lt;
		logic ltu;
	} alu_flags_t;

endpackage

//--- fetch_unit.sv
module fetch_unit #(
	parameter int imem_words = 256
) (
	input logic clk,
	input logic rst,
	input core_pkg::ctrl_t ctrl,
	input logic prog_we,
	input core_pkg::word_t prog_addr,	// byte address
	input core_pkg::word_t prog_data,
	output core_pkg::word_t pc,
	output core_pkg::word_t instr
);

	localparam int idx_w = $clog2(imem_words);

	core_pkg::word_t mem [imem_words];
	core_pkg::word_t mem_q;

	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (prog_we)
		begin
			mem[prog_addr[idx_w+1:2]] <= prog_data;
		end
	end

	always_ff @(posedge clk)
	begin
		mem_q <= mem[pc[idx_w+1:2]];	// sync read
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.ir_we)
		begin
			instr <= mem_q;
		end
	end

	// ------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pc <= '0;
		end
		else if (ctrl.pc_we)
		begin
			pc <= pc + (ctrl.pc_branch ? ctrl.imm : 32'd4);
		end
	end

endmodule

//--- project.f
core_pkg.sv
step_timer.sv
control_fsm.sv
fetch_unit.sv
register_file.sv
alu.sv
riscv_core.sv
riscv_core_properties.sv
tb_riscv_core.sv

//--- register_file.sv
module register_file (
	input logic clk,
	input logic rst,
	input core_pkg::ctrl_t ctrl,
	input core_pkg::word_t wdata,
	output core_pkg::word_t rs1_data,
	output core_pkg::word_t rs2_data
);

	core_pkg::word_t regs [32];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (ctrl.reg_we && ctrl.rd != 5'd0)	// x0 stays zero
		begin
			regs[ctrl.rd] <= wdata;
		end
	end

	assign rs1_data = regs[ctrl.rs1];
	assign rs2_data = regs[ctrl.rs2];

endmodule

//--- riscv_core.sv
module riscv_core #(
	parameter int imem_words = 256,
	parameter int fetch_cycles = 2,
	parameter int alu_cycles = 2
) (
	input logic clk,
	input logic rst,
	input logic prog_we,
	input core_pkg::word_t prog_addr,
	input core_pkg::word_t prog_data,
	output logic print_valid,
	output core_pkg::word_t print_data,
	output logic halted
);

	core_pkg::ctrl_t ctrl;
	core_pkg::alu_flags_t flags;
	core_pkg::word_t pc;
	core_pkg::word_t instr;
	core_pkg::word_t rs1_data;
	core_pkg::word_t rs2_data;
	core_pkg::word_t alu_b;
	core_pkg::word_t alu_result;
	core_pkg::word_t wdata;
	logic timer_clear;
	logic timer_run;
	logic [7:0] count;

	// ------------------------------
	control_fsm #(
		.fetch_cycles(fetch_cycles),
		.alu_cycles(alu_cycles)
	) control_fsm_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.rs1_data(rs1_data),
		.flags(flags),
		.count(count),
		.ctrl(ctrl),
		.timer_clear(timer_clear),
		.timer_run(timer_run),
		.print_valid(print_valid),
		.halted(halted)
	);

	step_timer step_timer_i (
		.clk(clk),
		.rst(rst),
		.clear(timer_clear),
		.run(timer_run),
		.count(count)
	);

	fetch_unit #(
		.imem_words(imem_words)
	) fetch_unit_i (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.pc(pc),
		.instr(instr)
	);

	register_file register_file_i (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.wdata(wdata),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	alu alu_i (
		.a(rs1_data),
		.b(alu_b),
		.op(ctrl.alu_op),
		.result(alu_result),
		.flags(flags)
	);

	// ------------------------------
	assign alu_b = ctrl.alu_b_imm ? ctrl.imm : rs2_data;

	always_comb
	begin
		case (ctrl.wb_sel)
			core_pkg::wb_imm: wdata = ctrl.imm;
			core_pkg::wb_pc4: wdata = pc + 32'd4;	// jal link
			default: wdata = alu_result;
		endcase
	end

	assign print_data = rs2_data;	// a1 while printing

endmodule

//--- riscv_core_properties.sv
module riscv_core_properties (
	input logic clk,
	input logic rst,
	input logic print_valid,
	input logic halted
);
	timeunit 1ns;
	timeprecision 100ps;

	// ------------------------------
	halt_sticky: assert property (
		@(posedge clk) disable iff (!rst)
		halted |=> halted
	)
	else $error("halted dropped after being set");

	no_print_halted: assert property (
		@(posedge clk) disable iff (!rst)
		halted |-> !print_valid
	)
	else $error("print_valid high while halted");

	// one cycle per print
	print_single: assert property (
		@(posedge clk) disable iff (!rst)
		print_valid |=> !print_valid
	)
	else $error("print_valid high on two cycles in a row");

endmodule

//--- step_timer.sv
module step_timer (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic run,
	output logic [7:0] count
);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			count <= 8'd0;
		end
		else if (clear)
		begin
			count <= 8'd0;
		end
		else if (run && count != 8'hff)	// hold at max
		begin
			count <= count + 8'd1;
		end
	end

endmodule

//--- stim_program.txt
# P <byte address> <instruction word>  program word, mnemonic after it
# E <value>  expected print value, in print order
P 00000000 00100513 addi a0, zero, 1
P 00000004 f9c00293 addi t0, zero, -100
P 00000008 03500313 addi t1, zero, 53
P 0000000c 00728593 addi a1, t0, 7
P 00000010 00000073 ecall
P 00000014 0f02f593 andi a1, t0, 0xf0
P 00000018 00000073 ecall
P 0000001c 70036593 ori a1, t1, 0x700
P 00000020 00000073 ecall
P 00000024 fff2c593 xori a1, t0, -1
P 00000028 00000073 ecall
P 0000002c 006285b3 add a1, t0, t1
P 00000030 00000073 ecall
P 00000034 405305b3 sub a1, t1, t0
P 00000038 00000073 ecall
P 0000003c 0062f5b3 and a1, t0, t1
P 00000040 00000073 ecall
P 00000044 0062e5b3 or a1, t0, t1
P 00000048 00000073 ecall
P 0000004c 0062c5b3 xor a1, t0, t1
P 00000050 00000073 ecall
P 00000054 123455b7 lui a1, 0x12345
P 00000058 00000073 ecall
P 0000005c 01c31593 slli a1, t1, 28
P 00000060 00000073 ecall
P 00000064 0042d593 srli a1, t0, 4
P 00000068 00000073 ecall
P 0000006c 4042d593 srai a1, t0, 4
P 00000070 00000073 ecall
P 00000074 006315b3 sll a1, t1, t1
P 00000078 00000073 ecall
P 0000007c 0062d5b3 srl a1, t0, t1
P 00000080 00000073 ecall
P 00000084 4062d5b3 sra a1, t0, t1
P 00000088 00000073 ecall
P 0000008c 00300413 addi s0, zero, 3
P 00000090 00040593 loop: addi a1, s0, 0
P 00000094 00000073 ecall
P 00000098 fff40413 addi s0, s0, -1
P 0000009c fe041ae3 bne s0, zero, loop
P 000000a0 0062c663 blt t0, t1, +12 (taken)
P 000000a4 0b100593 addi a1, zero, 0xb1
P 000000a8 00000073 ecall
P 000000ac 00534663 blt t1, t0, +12 (not taken)
P 000000b0 0b200593 addi a1, zero, 0xb2
P 000000b4 00000073 ecall
P 000000b8 00535663 bge t1, t0, +12 (taken)
P 000000bc 0b300593 addi a1, zero, 0xb3
P 000000c0 00000073 ecall
P 000000c4 0062d663 bge t0, t1, +12 (not taken)
P 000000c8 0b400593 addi a1, zero, 0xb4
P 000000cc 00000073 ecall
P 000000d0 00536663 bltu t1, t0, +12 (taken)
P 000000d4 0b500593 addi a1, zero, 0xb5
P 000000d8 00000073 ecall
P 000000dc 0062e663 bltu t0, t1, +12 (not taken)
P 000000e0 0b600593 addi a1, zero, 0xb6
P 000000e4 00000073 ecall
P 000000e8 0062f663 bgeu t0, t1, +12 (taken)
P 000000ec 0b700593 addi a1, zero, 0xb7
P 000000f0 00000073 ecall
P 000000f4 00537663 bgeu t1, t0, +12 (not taken)
P 000000f8 0b800593 addi a1, zero, 0xb8
P 000000fc 00000073 ecall
P 00000100 00c005ef jal a1, +12
P 00000104 0ee00593 addi a1, zero, 0xee (skipped)
P 00000108 00000073 ecall (skipped)
P 0000010c 00000073 ecall
P 00000110 00500013 addi zero, zero, 5
P 00000114 00000593 addi a1, zero, 0
P 00000118 00000073 ecall
P 0000011c 00000513 addi a0, zero, 0
P 00000120 00000073 ecall (halt)
E ffffffa3 addi
E 00000090 andi
E 00000735 ori
E 00000063 xori
E ffffffd1 add
E 00000099 sub
E 00000014 and
E ffffffbd or
E ffffffa9 xor
E 12345000 lui
E 50000000 slli
E 0ffffff9 srli
E fffffff9 srai
E 06a00000 sll
E 000007ff srl
E ffffffff sra
E 00000003 countdown
E 00000002 countdown
E 00000001 countdown
E 000000b2 blt not taken
E 000000b4 bge not taken
E 000000b6 bltu not taken
E 000000b8 bgeu not taken
E 00000104 jal link
E 00000000 x0 read back

//--- tb_riscv_core.sv
module tb_riscv_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_cycles = 5000;
	localparam int quiet_cycles = 10;

	logic clk;
	logic rst;
	logic prog_we;
	core_pkg::word_t prog_addr;
	core_pkg::word_t prog_data;
	logic print_valid;
	core_pkg::word_t print_data;
	logic halted;

	core_pkg::word_t expected [$];	// print values in order
	int print_count;
	int cycle;

	riscv_core #(
		.imem_words(256),
		.fetch_cycles(2),
		.alu_cycles(2)
	) riscv_core_i (
		.clk(clk),
		.rst(rst),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.print_valid(print_valid),
		.print_data(print_data),
		.halted(halted)
	);

	bind riscv_core riscv_core_properties riscv_core_properties_i (
		.clk(clk),
		.rst(rst),
		.print_valid(print_valid),
		.halted(halted)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk;
		end
	end

	// ------------------------------
	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input core_pkg::word_t actual, input core_pkg::word_t want,
		input string what);
		if (actual !== want)
		begin
			$display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, actual, want);
			$display("ERRORS FOUND");
			$fatal(1, "value check failed");
		end
	endtask

	// program words go in on falling edges, expected prints into the queue
	task automatic load_program();
		int fd;
		int status;
		string line;
		core_pkg::word_t addr;
		core_pkg::word_t data;
		fd = $fopen("stim_program.txt", "r");
		if (fd == 0)
		begin
			stop_run("could not open stim_program.txt for reading");
		end
		else
		begin
			while (!$feof(fd))
			begin
				status = $fgets(line, fd);
				if (status != 0)	// nothing read at end of file
				begin
					if ($sscanf(line, "P %h %h", addr, data) == 2)
					begin
						@(negedge clk);
						prog_we = 1'b1;
						prog_addr = addr;
						prog_data = data;
					end
					else if ($sscanf(line, "E %h", data) == 1)
					begin
						expected.push_back(data);
					end
				end
			end
			$fclose(fd);
			@(negedge clk);
			prog_we = 1'b0;
		end
	endtask

	// ------------------------------
	initial
	begin
		rst = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		print_count = 0;
		cycle = 0;

		load_program();	// core held in reset meanwhile
		repeat (4) @(negedge clk);
		rst = 1'b1;
		check_value(32'(halted), 32'd0, "halted after reset");
		check_value(32'(print_valid), 32'd0, "print_valid after reset");

		while (!halted && cycle < max_cycles)
		begin
			@(negedge clk);
			cycle++;
			if (print_valid)
			begin
				if (print_count >= expected.size())
				begin
					stop_run("the core printed more values than the stim file expects");
				end
				else
				begin
					check_value(print_data, expected[print_count],
						$sformatf("print %0d", print_count));
					print_count++;
				end
			end
		end
		if (!halted)
		begin
			stop_run("timeout: the core did not halt within the cycle limit");
		end

		check_value(32'(print_count), 32'(expected.size()), "print count");

		// outputs stay put after the halt
		for (int i = 0; i < quiet_cycles; i++)
		begin
			@(negedge clk);
			if (print_valid || !halted)
			begin
				stop_run("the core printed or left the halt state after halting");
			end
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule
